// File: ulpi_link.f
+incdir+rtl
rtl/ulpi_pkg.sv
rtl/link_pkg.sv
rtl/ulpi_reset_gen.sv
rtl/ulpi_rx.sv
rtl/ulpi_tx.sv
rtl/ulpi_reg_port.sv
rtl/ulpi_link.sv
testbench/ulpi_phy_model.sv
testbench/tb_ulpi_link.sv

// File: Bender.yml
package:
  name: ulpi_link

export_include_dirs:
  - rtl

sources:
  - rtl/ulpi_pkg.sv
  - rtl/link_pkg.sv
  - rtl/ulpi_reset_gen.sv
  - rtl/ulpi_rx.sv
  - rtl/ulpi_tx.sv
  - rtl/ulpi_reg_port.sv
  - rtl/ulpi_link.sv
  - target: test
    files:
      - testbench/ulpi_phy_model.sv
      - testbench/tb_ulpi_link.sv

// File: testbench/tb_ulpi_link.sv
`include "ulpi_consts.svh"

`default_nettype none

module tb_ulpi_link
  import ulpi_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 2000;  // clocks per wait loop
  localparam int RX_CMDS    = 8;
  localparam int PACKETS    = 4;

  logic        clock = 1'b0;
  logic        areset_n;
  logic        ulpi_dir;
  logic        ulpi_nxt;
  logic        ulpi_stp;
  wire ulpi_byte_t ulpi_data;  // shared by link and phy
  logic        s_axis_tvalid;
  logic        s_axis_tready;
  logic        s_axis_tlast;
  ulpi_byte_t  s_axis_tdata;
  logic        m_axis_tvalid;
  logic        m_axis_tready;
  logic        m_axis_tlast;
  ulpi_byte_t  m_axis_tdata;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [`ULPI_REG_ADDR_W-1:0] wb_adr;
  ulpi_byte_t  wb_dat_w;
  ulpi_byte_t  wb_dat_r;
  logic        wb_ack;
  line_state_t line_state;
  logic        vbus_valid;
  logic        rx_active;
  logic        rx_overflow;
  logic        usb_reset;
  logic        reset;

  integer      seed = 32'h6cd7;
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;
  ulpi_byte_t  pkt[$];     // packet under test
  ulpi_byte_t  rx_got[$];  // beats seen on m_axis
  logic        rx_last[$];

  ulpi_link i_ulpi_link (
    .clock          (clock),
    .areset_n       (areset_n),
    .ulpi_dir_i     (ulpi_dir),
    .ulpi_nxt_i     (ulpi_nxt),
    .ulpi_stp_o     (ulpi_stp),
    .ulpi_data_io   (ulpi_data),
    .s_axis_tvalid_i(s_axis_tvalid),
    .s_axis_tready_o(s_axis_tready),
    .s_axis_tlast_i (s_axis_tlast),
    .s_axis_tdata_i (s_axis_tdata),
    .m_axis_tvalid_o(m_axis_tvalid),
    .m_axis_tready_i(m_axis_tready),
    .m_axis_tlast_o (m_axis_tlast),
    .m_axis_tdata_o (m_axis_tdata),
    .wb_cyc_i       (wb_cyc),
    .wb_stb_i       (wb_stb),
    .wb_we_i        (wb_we),
    .wb_adr_i       (wb_adr),
    .wb_dat_i       (wb_dat_w),
    .wb_dat_o       (wb_dat_r),
    .wb_ack_o       (wb_ack),
    .line_state_o   (line_state),
    .vbus_valid_o   (vbus_valid),
    .rx_active_o    (rx_active),
    .rx_overflow_o  (rx_overflow),
    .usb_reset_o    (usb_reset),
    .reset_o        (reset)
  );

  ulpi_phy_model #(.SEED(32'h6cd7)) i_phy (
    .clock  (clock),
    .dir_o  (ulpi_dir),
    .nxt_o  (ulpi_nxt),
    .stp_i  (ulpi_stp),
    .data_io(ulpi_data)
  );

  always #5 clock = ~clock;

  // collect received beats at the falling edge
  always @(negedge clock) begin
    if (m_axis_tvalid && m_axis_tready) begin
      rx_got.push_back(m_axis_tdata);
      rx_last.push_back(m_axis_tlast);
    end
  end

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timed out while waiting for %s", what);
  endtask

  function automatic void fill_packet(input int len);
    pkt.delete();
    for (int i = 0; i < len; i++) pkt.push_back(ulpi_byte_t'($random(seed)));
  endfunction

  // offer pkt on s_axis until every byte is taken
  task automatic stream_tx_packet();
    int sent;
    int waited;
    sent   = 0;
    waited = 0;
    @(posedge clock);
    s_axis_tvalid <= 1'b1;
    s_axis_tdata  <= pkt[0];
    s_axis_tlast  <= (pkt.size() == 1);
    while (sent < pkt.size() && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
      if (s_axis_tready) sent++;
      @(posedge clock);
      if (sent < pkt.size()) begin
        s_axis_tdata <= pkt[sent];
        s_axis_tlast <= (sent == pkt.size() - 1);
      end else begin
        s_axis_tvalid <= 1'b0;
      end
    end
    if (sent < pkt.size()) begin
      note_timeout("the link to take the transmit packet");
      s_axis_tvalid <= 1'b0;
    end
  endtask

  task automatic wait_for_stp();
    int waited;
    waited = 0;
    while (i_phy.stp_count == 0 && waited < WAIT_LIMIT) begin
      @(posedge clock);  // model state settles at negedge
      waited++;
    end
    if (i_phy.stp_count == 0) note_timeout("STP from the link");
  endtask

  // one classic cycle held until ack
  task automatic wb_access(input logic we, input logic [`ULPI_REG_ADDR_W-1:0] adr,
                           input ulpi_byte_t wdata, output ulpi_byte_t rdata);
    int   waited;
    logic acked;
    waited = 0;
    acked  = 1'b0;
    rdata  = '0;
    @(posedge clock);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    while (!acked && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
      if (wb_ack) begin
        acked = 1'b1;
        rdata = wb_dat_r;
      end
    end
    if (!acked) note_timeout("a Wishbone ack");
    @(posedge clock);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  initial begin
    ulpi_byte_t b;
    ulpi_byte_t rd;
    ulpi_byte_t last_cmd;
    logic [`ULPI_REG_ADDR_W-1:0] adr;
    int len;
    int waited;

    areset_n      = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    s_axis_tdata  = '0;
    m_axis_tready = 1'b1;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    last_cmd      = 8'h01;
    #1 areset_n = 1'b0;

    // outputs quiet while in reset
    @(negedge clock);
    check_equal("stp in reset", 0, ulpi_stp);
    check_equal("s_axis_tready in reset", 0, s_axis_tready);
    check_equal("wb_ack in reset", 0, wb_ack);
    check_equal("m_axis_tvalid in reset", 0, m_axis_tvalid);
    check_equal("reset_o in reset", 1, reset);
    @(posedge clock);
    areset_n <= 1'b1;
    for (int edge_no = 1; edge_no <= 4; edge_no++) begin
      @(posedge clock);
      @(negedge clock);
      check_equal($sformatf("reset_o after edge %0d", edge_no), edge_no < 3, reset);
    end

    // rx cmd decode
    for (int n = 0; n < RX_CMDS; n++) begin
      b = ulpi_byte_t'($random(seed));
      if (b[1:0] == 2'b00) b[1:0] = 2'b01;  // se0 would start a bus reset
      if (n == 0) b[5:2] = 4'b0111;  // vbus valid and rxactive at least once
      i_phy.turn_around();
      i_phy.hold_rx_cmd(b, 1);
      i_phy.release_bus();
      @(negedge clock);
      check_equal("rx cmd line state", b[1:0], line_state);
      check_equal("rx cmd vbus valid", b[3:2] == 2'b11, vbus_valid);
      check_equal("rx cmd rx active", b[5:4] == 2'b01, rx_active);
      last_cmd = b;
    end

    // receive with ready held high
    for (int p = 0; p < PACKETS; p++) begin
      len = 1 + ($random(seed) & 15);
      fill_packet(len);
      @(posedge clock);
      rx_got.delete();
      rx_last.delete();
      i_phy.turn_around();
      foreach (pkt[i]) i_phy.put_rx_byte(pkt[i]);
      i_phy.release_bus();
      waited = 0;
      while (rx_got.size() < len && waited < WAIT_LIMIT) begin
        @(posedge clock);
        waited++;
      end
      if (rx_got.size() < len) note_timeout("received packet bytes on m_axis");
      repeat (2) @(posedge clock);  // no extra beats
      check_equal("rx packet length", len, rx_got.size());
      for (int i = 0; i < len; i++) begin
        check_equal($sformatf("rx byte %0d", i), pkt[i], rx_got[i]);
        check_equal($sformatf("rx last %0d", i), i == len - 1, rx_last[i]);
      end
    end
    check_equal("no overflow with ready high", 0, rx_overflow);

    // transmit with random nxt stalls
    for (int p = 0; p < PACKETS; p++) begin
      len = 1 + ($random(seed) & 15);
      fill_packet(len);
      i_phy.clear_log();
      stream_tx_packet();
      wait_for_stp();
      repeat (3) @(posedge clock);
      check_equal("tx bytes at phy", len, i_phy.tx_log.size());
      check_equal("tx cmd byte", {`ULPI_CMD_TRANSMIT, 2'b00, pkt[0][3:0]}, i_phy.tx_log[0]);
      for (int i = 1; i < len; i++) begin
        check_equal($sformatf("tx byte %0d", i), pkt[i], i_phy.tx_log[i]);
      end
      check_equal("tx stp clocks", 1, i_phy.stp_count);
      check_equal("tx stp after last byte", 1, i_phy.stp_gap);
      check_equal("tx stp data", 0, i_phy.stp_data);
    end

    // register write, then status reads
    adr = $random(seed);
    b   = ulpi_byte_t'($random(seed));
    i_phy.clear_log();
    wb_access(1'b1, adr, b, rd);
    check_equal("reg write bytes", 2, i_phy.tx_log.size());
    check_equal("reg write cmd", {`ULPI_CMD_REGWRITE, adr}, i_phy.tx_log[0]);
    check_equal("reg write data", b, i_phy.tx_log[1]);
    check_equal("reg write stp clocks", 1, i_phy.stp_count);
    check_equal("reg write stp data", 0, i_phy.stp_data);
    wb_access(1'b0, `ULPI_STATUS_ADDR, '0, rd);
    check_equal("status read", last_cmd, rd);
    wb_access(1'b0, `ULPI_STATUS_ADDR + 1, '0, rd);
    check_equal("unmapped read", 0, rd);

    // receive with ready low sets the sticky overflow
    @(posedge clock);
    m_axis_tready <= 1'b0;
    fill_packet(3);
    i_phy.turn_around();
    foreach (pkt[i]) i_phy.put_rx_byte(pkt[i]);
    i_phy.release_bus();
    waited = 0;
    while (!rx_overflow && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (!rx_overflow) note_timeout("the receive overflow flag");
    check_equal("rx overflow", 1, rx_overflow);
    @(posedge clock);
    m_axis_tready <= 1'b1;

    // bus reset from a long se0
    i_phy.turn_around();
    i_phy.hold_rx_cmd(8'h0c, `ULPI_BUS_RESET_CYCLES);  // se0 with vbus valid
    i_phy.release_bus();
    @(negedge clock);
    check_equal("usb reset before full se0 run", 0, usb_reset);
    waited = 0;
    while (!usb_reset && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (!usb_reset) note_timeout("usb_reset_o to rise");
    check_equal("usb reset after se0 run", 1, usb_reset);
    i_phy.turn_around();
    i_phy.hold_rx_cmd(8'h0d, 1);  // j state ends the reset
    i_phy.release_bus();
    waited = 0;
    while (usb_reset && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (usb_reset) note_timeout("usb_reset_o to fall");
    check_equal("usb reset after j", 0, usb_reset);
    check_equal("line state after j", 1, line_state);
    check_equal("overflow cleared by bus reset", 0, rx_overflow);

    repeat (2) @(posedge clock);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/ulpi_phy_model.sv
`default_nettype none

// behavioural ulpi phy, drives dir/nxt and logs what the link sends
module ulpi_phy_model
  import ulpi_pkg::*;
#(
  parameter int SEED = 1
) (
  input  logic       clock,
  output logic       dir_o,
  output logic       nxt_o,
  input  logic       stp_i,
  inout  wire ulpi_byte_t data_io
);

  timeunit 1ns;
  timeprecision 100ps;

  logic       rx_nxt;        // nxt while the phy owns the bus
  logic       tx_nxt;        // nxt toward the link
  ulpi_byte_t rx_data;
  logic       link_busy;     // link has a tx cmd or payload going
  integer     stall_seed;
  int         cycle;
  int         last_accept;   // cycle of latest accepted byte

  ulpi_byte_t tx_log[$];     // bytes taken from the link, in order
  int         stp_count;
  int         stp_gap;       // clocks from last accepted byte to stp
  ulpi_byte_t stp_data;      // bus value in the stp clock

  assign data_io = dir_o ? rx_data : 'z;
  assign nxt_o   = dir_o ? rx_nxt : tx_nxt;

  initial begin
    dir_o       = 1'b0;
    rx_nxt      = 1'b0;
    tx_nxt      = 1'b0;
    rx_data     = '0;
    link_busy   = 1'b0;
    stall_seed  = SEED;
    cycle       = 0;
    last_accept = 0;
    stp_count   = 0;
    stp_gap     = 0;
    stp_data    = '0;
  end

  // bus is stable at the falling edge
  always @(negedge clock) begin
    cycle = cycle + 1;
    if (!dir_o) begin
      if (stp_i) begin
        stp_count = stp_count + 1;
        stp_gap   = cycle - last_accept;
        stp_data  = data_io;
        link_busy = 1'b0;  // end of link transfer
      end else begin
        if (data_io != '0) link_busy = 1'b1;  // a tx cmd is never zero
        if (nxt_o && link_busy) begin
          tx_log.push_back(data_io);
          last_accept = cycle;
        end
      end
    end
  end

  // about one stall clock in four
  always @(posedge clock) begin
    tx_nxt <= link_busy && (($random(stall_seed) & 3) != 0);
  end

  task automatic turn_around();
    @(posedge clock);
    dir_o   <= 1'b1;
    rx_nxt  <= 1'b0;
    rx_data <= '0;
  endtask

  // rx cmd on the bus for a number of clocks
  task automatic hold_rx_cmd(input ulpi_byte_t value, input int clocks);
    repeat (clocks) begin
      @(posedge clock);
      rx_nxt  <= 1'b0;
      rx_data <= value;
    end
  endtask

  task automatic put_rx_byte(input ulpi_byte_t value);
    @(posedge clock);
    rx_nxt  <= 1'b1;  // packet data
    rx_data <= value;
  endtask

  task automatic release_bus();
    @(posedge clock);
    dir_o  <= 1'b0;
    rx_nxt <= 1'b0;
  endtask

  function automatic void clear_log();
    tx_log.delete();
    stp_count = 0;
  endfunction

endmodule

`default_nettype wire

// File: rtl/ulpi_link.sv
`default_nettype none

module ulpi_link
  import ulpi_pkg::*;
  import link_pkg::*;
(
  input  logic        clock,
  input  logic        areset_n,
  // ulpi pins
  input  logic        ulpi_dir_i,
  input  logic        ulpi_nxt_i,
  output logic        ulpi_stp_o,
  inout  wire ulpi_byte_t ulpi_data_io,
  // transmit stream
  input  logic        s_axis_tvalid_i,
  output logic        s_axis_tready_o,
  input  logic        s_axis_tlast_i,
  input  ulpi_byte_t  s_axis_tdata_i,
  // receive stream
  output logic        m_axis_tvalid_o,
  input  logic        m_axis_tready_i,
  output logic        m_axis_tlast_o,
  output ulpi_byte_t  m_axis_tdata_o,
  // phy register port
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  reg_addr_t   wb_adr_i,
  input  ulpi_byte_t  wb_dat_i,
  output ulpi_byte_t  wb_dat_o,
  output logic        wb_ack_o,
  // status
  output line_state_t line_state_o,
  output logic        vbus_valid_o,
  output logic        rx_active_o,
  output logic        rx_overflow_o,
  output logic        usb_reset_o,
  output logic        reset_o
);

  logic        core_reset;
  line_state_t line_state;
  ulpi_byte_t  rx_cmd;
  ulpi_byte_t  rx_data;   // pins as seen by the receiver
  ulpi_byte_t  tx_data;
  logic        reg_req;
  reg_addr_t   reg_addr;
  ulpi_byte_t  reg_data;
  logic        reg_done;

  // link drives the pins only while dir is low
  assign ulpi_data_io = ulpi_dir_i ? 'z : tx_data;
  assign rx_data      = ulpi_data_io;
  assign line_state_o = line_state;

  ulpi_reset_gen i_reset_gen (
    .clock       (clock),
    .areset_n    (areset_n),
    .line_state_i(line_state),
    .reset_o     (reset_o),
    .usb_reset_o (usb_reset_o),
    .core_reset_o(core_reset)
  );

  ulpi_rx i_rx (
    .clock          (clock),
    .areset_n       (areset_n),
    .core_reset_i   (core_reset),
    .ulpi_dir_i     (ulpi_dir_i),
    .ulpi_nxt_i     (ulpi_nxt_i),
    .ulpi_data_i    (rx_data),
    .line_state_o   (line_state),
    .vbus_valid_o   (vbus_valid_o),
    .rx_active_o    (rx_active_o),
    .rx_cmd_o       (rx_cmd),
    .m_axis_tvalid_o(m_axis_tvalid_o),
    .m_axis_tready_i(m_axis_tready_i),
    .m_axis_tlast_o (m_axis_tlast_o),
    .m_axis_tdata_o (m_axis_tdata_o),
    .rx_overflow_o  (rx_overflow_o)
  );

  ulpi_tx i_tx (
    .clock          (clock),
    .areset_n       (areset_n),
    .core_reset_i   (core_reset),
    .ulpi_dir_i     (ulpi_dir_i),
    .ulpi_nxt_i     (ulpi_nxt_i),
    .ulpi_stp_o     (ulpi_stp_o),
    .ulpi_data_o    (tx_data),
    .s_axis_tvalid_i(s_axis_tvalid_i),
    .s_axis_tready_o(s_axis_tready_o),
    .s_axis_tlast_i (s_axis_tlast_i),
    .s_axis_tdata_i (s_axis_tdata_i),
    .reg_req_i      (reg_req),
    .reg_addr_i     (reg_addr),
    .reg_data_i     (reg_data),
    .reg_done_o     (reg_done)
  );

  ulpi_reg_port i_reg_port (
    .clock       (clock),
    .areset_n    (areset_n),
    .core_reset_i(core_reset),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .reg_req_o   (reg_req),
    .reg_addr_o  (reg_addr),
    .reg_data_o  (reg_data),
    .reg_done_i  (reg_done),
    .rx_cmd_i    (rx_cmd)
  );

endmodule

`default_nettype wire

// File: rtl/ulpi_reg_port.sv
`include "ulpi_consts.svh"

`default_nettype none

module ulpi_reg_port
  import ulpi_pkg::*;
  import link_pkg::*;
(
  input  logic       clock,
  input  logic       areset_n,
  input  logic       core_reset_i,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  input  logic       wb_we_i,
  input  reg_addr_t  wb_adr_i,
  input  ulpi_byte_t wb_dat_i,
  output ulpi_byte_t wb_dat_o,
  output logic       wb_ack_o,
  output logic       reg_req_o,
  output reg_addr_t  reg_addr_o,
  output ulpi_byte_t reg_data_o,
  input  logic       reg_done_i,
  input  ulpi_byte_t rx_cmd_i
);

  localparam reg_addr_t STATUS_ADDR = reg_addr_t'(`ULPI_STATUS_ADDR);

  logic       bus_cycle;
  logic       start;      // new cycle seen while idle
  logic       ack_q;
  logic       req_q;      // write pending in the transmitter
  reg_addr_t  addr_q;
  ulpi_byte_t wdata_q;
  ulpi_byte_t rdata_q;

  assign bus_cycle = wb_cyc_i & wb_stb_i;
  assign start     = bus_cycle & ~req_q & ~ack_q;  // ack clock still has stb high

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      ack_q <= 1'b0;
      req_q <= 1'b0;
    end else if (core_reset_i) begin
      ack_q <= 1'b0;
      req_q <= 1'b0;
    end else begin
      ack_q <= (start & ~wb_we_i) | (req_q & reg_done_i);  // read now, write after done
      if (start && wb_we_i) req_q <= 1'b1;
      else if (reg_done_i) req_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start && wb_we_i) begin
      addr_q  <= wb_adr_i;
      wdata_q <= wb_dat_i;
    end
    if (start && !wb_we_i) begin
      rdata_q <= (wb_adr_i == STATUS_ADDR) ? rx_cmd_i : '0;  // only status is readable
    end
  end

  assign wb_ack_o   = ack_q;
  assign wb_dat_o   = rdata_q;
  assign reg_req_o  = req_q;
  assign reg_addr_o = addr_q;
  assign reg_data_o = wdata_q;

  // classic handshake, one ack per cycle
  a_ack_single : assert property (
    @(posedge clock) disable iff (!areset_n)
    wb_ack_o |=> !wb_ack_o
  );

endmodule

`default_nettype wire

// File: rtl/ulpi_tx.sv
`include "ulpi_consts.svh"

`default_nettype none

module ulpi_tx
  import ulpi_pkg::*;
  import link_pkg::*;
(
  input  logic       clock,
  input  logic       areset_n,
  input  logic       core_reset_i,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  output logic       ulpi_stp_o,
  output ulpi_byte_t ulpi_data_o,
  input  logic       s_axis_tvalid_i,
  output logic       s_axis_tready_o,
  input  logic       s_axis_tlast_i,
  input  ulpi_byte_t s_axis_tdata_i,
  input  logic       reg_req_i,
  input  reg_addr_t  reg_addr_i,
  input  ulpi_byte_t reg_data_i,
  output logic       reg_done_o
);

  tx_state_t state_q;
  tx_state_t state_d;
  logic      is_reg_q;   // job in flight is a register write
  logic      start;
  logic      busy;       // cmd or payload on the bus
  pid_t      pid;
  ulpi_cmd_t cmd_code;

  assign start    = !ulpi_dir_i && (reg_req_i || s_axis_tvalid_i);  // only with bus ours
  assign busy     = (state_q == TX_CMD) || (state_q == TX_DATA);
  assign pid      = s_axis_tdata_i[3:0];  // first byte carries the pid
  assign cmd_code = is_reg_q ? `ULPI_CMD_REGWRITE : `ULPI_CMD_TRANSMIT;

  always_comb begin
    state_d = state_q;
    case (state_q)
      TX_IDLE: begin
        if (start) state_d = TX_CMD;
      end
      TX_CMD: begin
        // single byte packet has no payload phase
        if (ulpi_nxt_i) state_d = (!is_reg_q && s_axis_tlast_i) ? TX_STOP : TX_DATA;
      end
      TX_DATA: begin
        if (ulpi_nxt_i && (is_reg_q || s_axis_tlast_i)) state_d = TX_STOP;
      end
      TX_STOP: begin
        state_d = TX_IDLE;
      end
      default: begin
        state_d = TX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q  <= TX_IDLE;
      is_reg_q <= 1'b0;
    end else if (core_reset_i) begin
      state_q  <= TX_IDLE;
      is_reg_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == TX_IDLE && start) is_reg_q <= reg_req_i;  // register write wins
    end
  end

  // bus byte per state
  always_comb begin
    case (state_q)
      TX_CMD: begin
        if (is_reg_q) ulpi_data_o = {cmd_code, reg_addr_i};
        else ulpi_data_o = {cmd_code, 2'b00, pid};
      end
      TX_DATA: begin
        ulpi_data_o = is_reg_q ? reg_data_i : s_axis_tdata_i;
      end
      default: begin
        ulpi_data_o = '0;  // idle and stp clock drive zero
      end
    endcase
  end

  assign ulpi_stp_o      = (state_q == TX_STOP);
  assign s_axis_tready_o = busy && !is_reg_q && ulpi_nxt_i;  // phy back-pressure
  assign reg_done_o      = (state_q == TX_STOP) && is_reg_q;

  // stp is a single clock and only while the link owns the bus
  a_stp_pulse : assert property (
    @(posedge clock) disable iff (!areset_n)
    ulpi_stp_o |-> !ulpi_dir_i ##1 !ulpi_stp_o
  );

endmodule

`default_nettype wire

// File: rtl/ulpi_rx.sv
`default_nettype none

module ulpi_rx
  import ulpi_pkg::*;
(
  input  logic        clock,
  input  logic        areset_n,
  input  logic        core_reset_i,
  input  logic        ulpi_dir_i,
  input  logic        ulpi_nxt_i,
  input  ulpi_byte_t  ulpi_data_i,
  output line_state_t line_state_o,
  output logic        vbus_valid_o,
  output logic        rx_active_o,
  output ulpi_byte_t  rx_cmd_o,
  output logic        m_axis_tvalid_o,
  input  logic        m_axis_tready_i,
  output logic        m_axis_tlast_o,
  output ulpi_byte_t  m_axis_tdata_o,
  output logic        rx_overflow_o
);

  logic        dir_q;        // dir one clock back
  logic        turn;         // first dir-high clock
  logic        rx_cycle;     // phy owns bus, past turnaround
  logic        cmd_in;
  logic        byte_in;
  logic        dir_fall;
  logic        push;         // held byte goes out
  ulpi_byte_t  rx_cmd_q;
  ulpi_byte_t  hold_q;       // byte waiting to learn if it is last
  logic        hold_vld_q;
  logic        out_vld_q;
  logic        out_last_q;
  ulpi_byte_t  out_data_q;
  logic        overflow_q;
  vbus_state_t vbus_state;
  rx_event_t   rx_event;

  assign turn     = ulpi_dir_i & ~dir_q;
  assign rx_cycle = ulpi_dir_i & dir_q;
  assign cmd_in   = rx_cycle & ~ulpi_nxt_i;  // rx cmd when nxt low
  assign byte_in  = rx_cycle & ulpi_nxt_i;   // packet data when nxt high
  assign dir_fall = ~ulpi_dir_i & dir_q;
  assign push     = hold_vld_q & (byte_in | dir_fall);

  // dir history and latest rx cmd byte
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      dir_q    <= 1'b0;
      rx_cmd_q <= 8'h01;  // fs idle j until the phy reports
    end else begin
      dir_q <= ulpi_dir_i;
      if (cmd_in) rx_cmd_q <= ulpi_data_i;
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      hold_vld_q <= 1'b0;
      out_vld_q  <= 1'b0;
      overflow_q <= 1'b0;
    end else if (core_reset_i) begin
      hold_vld_q <= 1'b0;
      out_vld_q  <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      hold_vld_q <= byte_in | (hold_vld_q & ~dir_fall);
      out_vld_q  <= push;  // one clock per beat, phy cannot wait
      if (out_vld_q && !m_axis_tready_i) overflow_q <= 1'b1;  // beat lost, sticky
    end
  end

  always_ff @(posedge clock) begin
    if (byte_in) hold_q <= ulpi_data_i;
    if (push) begin
      out_data_q <= hold_q;
      out_last_q <= dir_fall;  // end of turnaround closes the packet
    end
  end

  assign vbus_state = rx_cmd_q[3:2];
  assign rx_event   = rx_cmd_q[5:4];

  assign line_state_o  = rx_cmd_q[1:0];
  assign vbus_valid_o  = (vbus_state == 2'b11);
  assign rx_active_o   = (rx_event == 2'b01);
  assign rx_cmd_o      = rx_cmd_q;

  assign m_axis_tvalid_o = out_vld_q;
  assign m_axis_tlast_o  = out_last_q;
  assign m_axis_tdata_o  = out_data_q;
  assign rx_overflow_o   = overflow_q;

  // no stream beat is offered in a turnaround clock
  a_turn_no_beat : assert property (
    @(posedge clock) disable iff (!areset_n)
    turn |-> !m_axis_tvalid_o
  );

endmodule

`default_nettype wire

// File: rtl/ulpi_reset_gen.sv
`include "ulpi_consts.svh"

`default_nettype none

module ulpi_reset_gen
  import ulpi_pkg::*;
(
  input  logic        clock,
  input  logic        areset_n,
  input  line_state_t line_state_i,
  output logic        reset_o,
  output logic        usb_reset_o,
  output logic        core_reset_o
);

  localparam int unsigned SE0_W = $clog2(`ULPI_BUS_RESET_CYCLES + 1);
  localparam logic [SE0_W-1:0] SE0_LAST = SE0_W'(`ULPI_BUS_RESET_CYCLES - 1);
  localparam line_state_t LS_SE0 = 2'b00;

  logic [2:0]       sync_q;      // shifts in ones after release
  logic [SE0_W-1:0] se0_cnt_q;   // consecutive se0 clocks, saturates
  logic             usb_reset_q;

  // release is synchronous, assertion is not
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      sync_q <= 3'b000;
    end else begin
      sync_q <= {sync_q[1:0], 1'b1};
    end
  end

  assign reset_o = ~sync_q[2];  // low from the third edge on

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      se0_cnt_q   <= '0;
      usb_reset_q <= 1'b0;
    end else if (reset_o) begin
      se0_cnt_q   <= '0;
      usb_reset_q <= 1'b0;
    end else if (line_state_i == LS_SE0) begin
      if (se0_cnt_q != SE0_LAST) se0_cnt_q <= se0_cnt_q + 1'b1;
      else usb_reset_q <= 1'b1;  // nth se0 clock
    end else begin
      se0_cnt_q   <= '0;    // any other line state breaks the run
      usb_reset_q <= 1'b0;
    end
  end

  assign usb_reset_o  = usb_reset_q;
  assign core_reset_o = reset_o | usb_reset_q;

  // bus reset may only be flagged once the core is out of power-on reset
  a_no_bus_reset_in_reset : assert property (
    @(posedge clock) disable iff (!areset_n)
    $rose(usb_reset_o) |-> !reset_o
  );

endmodule

`default_nettype wire

// File: rtl/link_pkg.sv
`include "ulpi_consts.svh"

`default_nettype none

// link side types
package link_pkg;

  // phy register address, immediate form only
  typedef logic [`ULPI_REG_ADDR_W-1:0] reg_addr_t;

  // pid in the low nibble of a transmit cmd
  typedef logic [3:0] pid_t;

  // transmitter states
  typedef enum logic [1:0] {
    TX_IDLE,   // bus free, waiting for a job
    TX_CMD,    // tx cmd byte on the bus until nxt
    TX_DATA,   // payload bytes, one per nxt
    TX_STOP    // single stp clock, data zero
  } tx_state_t;

endpackage

`default_nettype wire

// File: rtl/ulpi_pkg.sv
`default_nettype none

// ulpi bus encoding
package ulpi_pkg;

  // one byte on the ulpi data pins
  typedef logic [7:0] ulpi_byte_t;

  // rx cmd byte fields
  // bits 1:0, linestate of d+/d-
  typedef logic [1:0] line_state_t;   // 0 is se0, 1 is j in fs idle

  // bits 3:2, vbus comparators
  typedef logic [1:0] vbus_state_t;   // 3 is vbus valid

  // bits 5:4, receive event
  typedef logic [1:0] rx_event_t;     // 1 is rxactive

  // tx cmd code in bits 7:6
  // transmit or register write, see ulpi_consts.svh
  typedef logic [1:0] ulpi_cmd_t;

endpackage

`default_nettype wire

// File: rtl/ulpi_consts.svh
`ifndef ULPI_CONSTS_SVH
`define ULPI_CONSTS_SVH

`default_nettype none

// tx cmd codes, upper two bits of the command byte
`define ULPI_CMD_TRANSMIT 2'b01   // packet transmit, low nibble is the pid
`define ULPI_CMD_REGWRITE 2'b10   // immediate register write, low six bits address

// phy register map, immediate addresses only
`define ULPI_REG_ADDR_W 6

// bus reset detection
// se0 must be seen on this many consecutive clocks
// smaller counts are fine for short simulations
`define ULPI_BUS_RESET_CYCLES 64

// wishbone side address map
`define ULPI_STATUS_ADDR 1        // read back of latest rx cmd byte

`default_nettype wire

`endif
